/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_board_bus
FILELIST   := filelist.f
COMMON     := --timing --assert --top-module $(TOP)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON)
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* board_bus_top.sv */
`timescale 1ns/1ps

module board_bus_top (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  board_pkg::addr_t  bus_address,
    input  board_pkg::data_t  bus_write_data,
    input  logic              bus_write_enable,
    input  logic              bus_read_enable,
    output board_pkg::data_t  bus_read_data,
    input  logic              PS2_CLK,
    input  logic              PS2_DAT,
    output logic              irq,
    input  logic              irq_ack,
    output board_pkg::ascii_t console_char,
    output logic              console_valid
);

    // Responder results into the combiner
    logic             mem_hit;
    board_pkg::data_t mem_data;
    logic             io_hit;
    board_pkg::data_t io_data;

    sys_bus_if bus_i ();

    // Master side of the bus comes from the pins
    assign bus_i.address      = bus_address;
    assign bus_i.write_data   = bus_write_data;
    assign bus_i.write_enable = bus_write_enable;
    assign bus_i.read_enable  = bus_read_enable;

    onchip_memory mem_i (
        .clk_50  (CLOCK_50),
        .bus     (bus_i.responder),
        .hit     (mem_hit),
        .rd_data (mem_data)
    );

    keyboard_console_io io_i (
        .clk_50        (CLOCK_50),
        .rst_n         (KEY0),
        .bus           (bus_i.responder),
        .ps2_clk       (PS2_CLK),
        .ps2_dat       (PS2_DAT),
        .irq_ack       (irq_ack),
        .irq           (irq),
        .console_char  (console_char),
        .console_valid (console_valid),
        .hit           (io_hit),
        .rd_data       (io_data)
    );

    read_data_mux mux_i (
        .clk_50    (CLOCK_50),
        .rst_n     (KEY0),
        .mem_hit   (mem_hit),
        .mem_data  (mem_data),
        .io_hit    (io_hit),
        .io_data   (io_data),
        .read_data (bus_read_data)
    );

endmodule

/* board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// Boot region, read-only, byte addresses
`define ROM_BASE 32'h0000_0000
`define ROM_SIZE 32'h0000_1000

// Writable RAM region
`define RAM_BASE 32'h0000_1000
`define RAM_SIZE 32'h0000_2000

// Depth of the on-chip memory in 32-bit words
`define MEM_WORDS 3072

// Memory-mapped keyboard and console registers
`define KEY_ADDR 32'h0000_3000
`define CONSOLE_ADDR 32'h0000_3004

// PS/2 release prefix
`define PS2_BREAK 8'hF0

`endif

/* board_pkg.sv */
package board_pkg;

    // Bus address and data, 64 bits wide
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // One on-chip memory word
    typedef logic [31:0] word_t;

    // Raw PS/2 scan code
    typedef logic [7:0] scan_t;

    // Decoded character
    typedef logic [7:0] ascii_t;

    // PS/2 frame receiver states
    // Start bit seen in idle, then eight data bits, parity, stop
    typedef enum logic [1:0] {
        ps2_idle,
        ps2_data,
        ps2_parity,
        ps2_stop
    } ps2_state_t;

endpackage

/* filelist.f */
+incdir+.
board_pkg.sv
sys_bus_if.sv
ps2_receiver.sv
onchip_memory.sv
keyboard_console_io.sv
read_data_mux.sv
board_bus_top.sv
tb_board_bus.sv

/* keyboard_console_io.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module keyboard_console_io (
    input  logic              clk_50,
    input  logic              rst_n,
    sys_bus_if.responder      bus,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    input  logic              irq_ack,
    output logic              irq,
    output board_pkg::ascii_t console_char,
    output logic              console_valid,
    output logic              hit,
    output board_pkg::data_t  rd_data
);

    board_pkg::scan_t  scan;
    board_pkg::ascii_t key_ascii;
    board_pkg::ascii_t last_char;
    logic              key_pressed;
    logic              key_released;
    logic              known_press;
    logic              console_wr;
    logic              console_wr_d;

    ps2_receiver rx_i (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_dat      (ps2_dat),
        .scan         (scan),
        .key_pressed  (key_pressed),
        .key_released (key_released)
    );

    // Set 2 scan codes to lower-case ASCII
    // Anything else decodes to zero and is ignored
    always_comb begin
        case (scan)
            8'h1C: key_ascii = "a";
            8'h32: key_ascii = "b";
            8'h21: key_ascii = "c";
            8'h23: key_ascii = "d";
            8'h24: key_ascii = "e";
            8'h2B: key_ascii = "f";
            8'h34: key_ascii = "g";
            8'h33: key_ascii = "h";
            8'h43: key_ascii = "i";
            8'h3B: key_ascii = "j";
            8'h42: key_ascii = "k";
            8'h4B: key_ascii = "l";
            8'h3A: key_ascii = "m";
            8'h31: key_ascii = "n";
            8'h44: key_ascii = "o";
            8'h4D: key_ascii = "p";
            8'h15: key_ascii = "q";
            8'h2D: key_ascii = "r";
            8'h1B: key_ascii = "s";
            8'h2C: key_ascii = "t";
            8'h3C: key_ascii = "u";
            8'h2A: key_ascii = "v";
            8'h1D: key_ascii = "w";
            8'h22: key_ascii = "x";
            8'h35: key_ascii = "y";
            8'h1A: key_ascii = "z";
            8'h45: key_ascii = "0";
            8'h16: key_ascii = "1";
            8'h1E: key_ascii = "2";
            8'h26: key_ascii = "3";
            8'h25: key_ascii = "4";
            8'h2E: key_ascii = "5";
            8'h36: key_ascii = "6";
            8'h3D: key_ascii = "7";
            8'h3E: key_ascii = "8";
            8'h46: key_ascii = "9";
            default: key_ascii = 8'h00;
        endcase
    end

    // Releases never raise an interrupt
    assign known_press = key_pressed && !key_released && (key_ascii != 8'h00);
    assign console_wr  = bus.write_enable
                         && (bus.address == board_pkg::addr_t'(`CONSOLE_ADDR));

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            irq           <= 1'b0;
            last_char     <= '0;
            hit           <= 1'b0;
            console_wr_d  <= 1'b0;
            console_valid <= 1'b0;
        end else begin
            if (known_press) begin
                last_char <= key_ascii;
            end
            // Acknowledge beats a press in the same cycle
            if (irq_ack) begin
                irq <= 1'b0;
            end else if (known_press) begin
                irq <= 1'b1;
            end
            hit <= bus.read_enable && (bus.address == board_pkg::addr_t'(`KEY_ADDR));
            // Rising edge of a console write, one strobe per burst
            console_wr_d  <= console_wr;
            console_valid <= console_wr && !console_wr_d;
        end
    end

    always_ff @(posedge clk_50) begin
        rd_data <= {56'd0, last_char};
        if (console_wr && !console_wr_d) begin
            console_char <= bus.write_data[7:0];
        end
    end

endmodule

/* onchip_memory.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module onchip_memory (
    input  logic             clk_50,
    sys_bus_if.responder     bus,
    output logic             hit,
    output board_pkg::data_t rd_data
);

    // Word index width for the whole array
    localparam int IDX_W = $clog2(`MEM_WORDS);

    // Boot words at the bottom, RAM words right after
    board_pkg::word_t mem [0:`MEM_WORDS-1];

    board_pkg::addr_t rom_off;
    board_pkg::addr_t ram_off;
    logic             rom_sel;
    logic             ram_sel;
    logic             any_sel;
    logic [IDX_W-1:0] idx;

    // Images loaded at their region bases
    initial begin
        $readmemh("rom.mem", mem, `ROM_BASE >> 2);
        $readmemh("ram.mem", mem, `RAM_BASE >> 2);
    end

    // Region decode by offset from each base
    // An address below a base wraps to a huge offset and misses
    assign rom_off = bus.address - board_pkg::addr_t'(`ROM_BASE);
    assign ram_off = bus.address - board_pkg::addr_t'(`RAM_BASE);
    assign rom_sel = rom_off < board_pkg::addr_t'(`ROM_SIZE);
    assign ram_sel = ram_off < board_pkg::addr_t'(`RAM_SIZE);
    assign any_sel = rom_sel || ram_sel;

    // Word index, byte offset dropped
    assign idx = bus.address[IDX_W+1:2];

    // Port shared by writes and reads
    // Nonblocking write means a same-cycle read sees the old word
    always_ff @(posedge clk_50) begin
        // Only the RAM region takes writes
        if (bus.write_enable && ram_sel) begin
            mem[idx] <= bus.write_data[31:0];
        end

        // Read word, zero-extended to bus width
        if (any_sel) begin
            rd_data <= {32'd0, mem[idx]};
        end else begin
            rd_data <= '0;
        end

        // Hit follows the read request by one cycle
        hit <= bus.read_enable && any_sel;
    end

endmodule

/* ps2_receiver.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module ps2_receiver (
    input  logic             clk_50,
    input  logic             rst_n,
    input  logic             ps2_clk,
    input  logic             ps2_dat,
    output board_pkg::scan_t scan,
    output logic             key_pressed,
    output logic             key_released
);

    // Two-flop synchronizers on the pins
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    // Last synchronized clock level
    logic       clk_prev;
    logic       clk_fall;
    logic       frame_ok;

    board_pkg::ps2_state_t state;
    logic [2:0]            bit_cnt;
    board_pkg::scan_t      shift_reg;
    logic                  parity_bit;
    // Set after an F0 prefix
    logic                  break_armed;

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            // Idle bus level is high
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Device changes data on rising edge, sample on falling
    assign clk_fall = clk_prev && !clk_sync[1];

    // Stop high and odd parity over data plus parity bit
    assign frame_ok = dat_sync[1] && (^{shift_reg, parity_bit});

    // Frame FSM, advances once per PS/2 clock
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            state        <= board_pkg::ps2_idle;
            bit_cnt      <= '0;
            break_armed  <= 1'b0;
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
        end else begin
            // Strobes last one cycle
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            if (clk_fall) begin
                case (state)
                    board_pkg::ps2_idle: begin
                        // Start bit is low
                        if (!dat_sync[1]) begin
                            state   <= board_pkg::ps2_data;
                            bit_cnt <= '0;
                        end
                    end
                    board_pkg::ps2_data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= board_pkg::ps2_parity;
                        end
                    end
                    board_pkg::ps2_parity: begin
                        state <= board_pkg::ps2_stop;
                    end
                    board_pkg::ps2_stop: begin
                        state <= board_pkg::ps2_idle;
                        // Bad frames fall through with no strobe
                        if (frame_ok) begin
                            if (shift_reg == `PS2_BREAK) begin
                                break_armed <= 1'b1;
                            end else if (break_armed) begin
                                break_armed  <= 1'b0;
                                key_released <= 1'b1;
                            end else begin
                                key_pressed <= 1'b1;
                            end
                        end
                    end
                    default: state <= board_pkg::ps2_idle;
                endcase
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk_50) begin
        if (clk_fall && state == board_pkg::ps2_data) begin
            shift_reg <= {dat_sync[1], shift_reg[7:1]};
        end
        if (clk_fall && state == board_pkg::ps2_parity) begin
            parity_bit <= dat_sync[1];
        end
        // Code published together with its strobe
        if (clk_fall && state == board_pkg::ps2_stop && frame_ok && shift_reg != `PS2_BREAK) begin
            scan <= shift_reg;
        end
    end

endmodule

/* ram.mem */
// RAM preload, one 32-bit hex word per line from RAM_BASE
5A000400
5A010401
5A020402
5A030403
5A040404
5A050405
5A060406
5A070407

/* read_data_mux.sv */
`timescale 1ns/1ps

module read_data_mux (
    input  logic             clk_50,
    input  logic             rst_n,
    input  logic             mem_hit,
    input  board_pkg::data_t mem_data,
    input  logic             io_hit,
    input  board_pkg::data_t io_data,
    output board_pkg::data_t read_data
);

    // Second stage of every bus read
    // Keyboard checked first, hits never overlap in practice
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (io_hit) begin
            read_data <= io_data;
        end else if (mem_hit) begin
            read_data <= mem_data;
        end else begin
            // Idle or unmapped cycles return zero
            read_data <= '0;
        end
    end

endmodule

/* rom.mem */
// Boot image, one 32-bit hex word per line from ROM_BASE
B0070000
B0080001
B0090002
B00A0003
B00B0004
B00C0005
B00D0006
B00E0007

/* sys_bus_if.sv */
`timescale 1ns/1ps

interface sys_bus_if;

    // Request side of the board bus
    board_pkg::addr_t address;
    board_pkg::data_t write_data;
    logic             write_enable;
    logic             read_enable;

    // CPU side drives the request
    modport master (
        output address,
        output write_data,
        output write_enable,
        output read_enable
    );

    // Memory and IO blocks only observe it
    modport responder (
        input address,
        input write_data,
        input write_enable,
        input read_enable
    );

endinterface

/* tb_board_bus.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module tb_board_bus;

    // PS/2 bit timing, device side
    localparam int PS2_HALF_NS = 200;
    // Eleven bits plus the idle gap, in 10 ns cycles
    localparam int FRAME_CYCLES = (11 * 2 * PS2_HALF_NS + 2 * PS2_HALF_NS) / 10;
    localparam int IRQ_WAIT = 100;
    // Per-test budgets: reset, boot, RAM, presses, rejected frames, console
    localparam int TEST_CYCLES = 20 + 40 + 80 + 3 * (FRAME_CYCLES + 20)
                                 + 4 * FRAME_CYCLES + 40 + 30;
    localparam int LIMIT = 2 * TEST_CYCLES;

    logic        clk;
    logic        key0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [63:0] bus_read_data;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        irq;
    logic        irq_ack;
    logic [7:0]  console_char;
    logic        console_valid;

    int          errors;
    int          tests;
    int          cycles;
    int          pulse_count;
    logic [7:0]  console_seen;
    // Shadow of written RAM words, keyed by byte address
    logic [31:0] ram_model [logic [31:0]];
    logic [31:0] ram_addrs [$];

    board_bus_top dut_i (
        .CLOCK_50         (clk),
        .KEY0             (key0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .PS2_CLK          (ps2_clk),
        .PS2_DAT          (ps2_dat),
        .irq              (irq),
        .irq_ack          (irq_ack),
        .console_char     (console_char),
        .console_valid    (console_valid)
    );

    always #5 clk = ~clk;

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // Console strobe monitor
    always @(posedge clk) begin
        if (console_valid) begin
            pulse_count  <= pulse_count + 1;
            console_seen <= console_char;
        end
    end

    // Outputs held low under reset
    assert property (@(posedge clk) !key0 |-> (bus_read_data == '0 && !irq && !console_valid))
        else begin
            $display("Mismatch at %0t: outputs not low during reset", $time);
            errors++;
        end

    // Strobe never longer than one cycle
    assert property (@(posedge clk) disable iff (!key0) console_valid |-> !$past(console_valid))
        else begin
            $display("Mismatch at %0t: console_valid high two cycles", $time);
            errors++;
        end

    // Ack clears irq at the sampling edge
    assert property (@(posedge clk) disable iff (!key0) $past(irq_ack) |-> !irq)
        else begin
            $display("Mismatch at %0t: irq still high after irq_ack", $time);
            errors++;
        end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_value(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %s finished, %0d failures so far", name, errors);
    endtask

    // Data comes back two edges after the request edge
    task automatic read_word(input logic [63:0] addr, output logic [63:0] data);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        next_cycle();
        bus_read_enable = 1'b0;
        next_cycle();
        data = bus_read_data;
    endtask

    task automatic write_word(input logic [63:0] addr, input logic [63:0] data);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        next_cycle();
        bus_write_enable = 1'b0;
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = bits[i];
            #(PS2_HALF_NS);
            ps2_clk = 1'b0;
            #(PS2_HALF_NS);
            ps2_clk = 1'b1;
        end
        #(2 * PS2_HALF_NS);
    endtask

    task automatic wait_for_irq(input string what);
        int n;
        n = 0;
        while (!irq && n < IRQ_WAIT) begin
            next_cycle();
            n++;
        end
        if (!irq) begin
            $display("irq never rose after %s", what);
            errors++;
        end
    endtask

    // Images as loaded from rom.mem and ram.mem
    function automatic logic [31:0] image_word(input int idx);
        if (idx < 'h400) begin
            return 32'hB007_0000 + 32'(idx) * 32'h0001_0001;
        end
        return 32'h5A00_0400 + 32'(idx - 'h400) * 32'h0001_0001;
    endfunction

    // Expected characters for the keys in use
    function automatic logic [7:0] ascii_of(input logic [7:0] code);
        case (code)
            8'h1C:   return 8'h61;
            8'h2E:   return 8'h35;
            8'h1A:   return 8'h7A;
            default: return 8'h00;
        endcase
    endfunction

    initial begin
        logic [63:0] got;
        logic [63:0] wdata;
        logic [31:0] a;
        logic [7:0]  last_key;
        logic [7:0]  keys [3];
        int          start;

        void'($urandom(32'h6bfc74e7));
        clk = 1'b0;
        key0 = 1'b1;
        bus_address = '0;
        bus_write_data = '0;
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        irq_ack = 1'b0;
        errors = 0;
        tests = 0;
        cycles = 0;
        pulse_count = 0;
        console_seen = '0;
        keys = '{8'h1C, 8'h2E, 8'h1A};
        last_key = '0;

        // Reset, clean falling edge on KEY0
        #1 key0 = 1'b0;
        repeat (8) begin
            next_cycle();
            expect_value(bus_read_data, 64'd0, "read_data in reset");
            expect_value({63'd0, irq}, 64'd0, "irq in reset");
            expect_value({63'd0, console_valid}, 64'd0, "console_valid in reset");
        end
        key0 = 1'b1;
        repeat (2) next_cycle();
        expect_value(bus_read_data, 64'd0, "read_data after reset");
        expect_value({63'd0, irq}, 64'd0, "irq after reset");
        expect_value({63'd0, console_valid}, 64'd0, "console_valid after reset");
        finish_test("reset");

        // Boot region reads and an ignored write
        for (int i = 0; i < 8; i++) begin
            read_word({32'd0, `ROM_BASE + 32'(i * 4)}, got);
            expect_value(got, {32'd0, image_word(i)}, "boot word");
        end
        write_word({32'd0, `ROM_BASE + 32'h8}, 64'hDEAD_BEEF_DEAD_BEEF);
        read_word({32'd0, `ROM_BASE + 32'h8}, got);
        expect_value(got, {32'd0, image_word(2)}, "boot word after write");
        finish_test("boot_reads");

        // Preloaded RAM words first, then random traffic
        for (int i = 0; i < 4; i++) begin
            read_word({32'd0, `RAM_BASE + 32'(i * 4)}, got);
            expect_value(got, {32'd0, image_word('h400 + i)}, "RAM preload");
        end
        for (int i = 0; i < 8; i++) begin
            a = `RAM_BASE + (($urandom % 32'd2048) << 2);
            wdata = {$urandom, $urandom};
            write_word({32'd0, a}, wdata);
            ram_model[a] = wdata[31:0];
            ram_addrs.push_back(a);
        end
        foreach (ram_addrs[i]) begin
            read_word({32'd0, ram_addrs[i]}, got);
            expect_value(got, {32'd0, ram_model[ram_addrs[i]]}, "RAM readback");
        end
        // Read and write together see the old word
        a = ram_addrs[0];
        wdata = {$urandom, $urandom};
        bus_address = {32'd0, a};
        bus_write_data = wdata;
        bus_write_enable = 1'b1;
        bus_read_enable = 1'b1;
        next_cycle();
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        next_cycle();
        expect_value(bus_read_data, {32'd0, ram_model[a]}, "same-cycle read");
        ram_model[a] = wdata[31:0];
        next_cycle();
        expect_value(bus_read_data, 64'd0, "idle cycle");
        read_word({32'd0, a}, got);
        expect_value(got, {32'd0, ram_model[a]}, "word after same-cycle write");
        read_word(64'h0000_0000_0000_3008, got);
        expect_value(got, 64'd0, "unmapped read");
        read_word(64'h0000_0000_0000_8000, got);
        expect_value(got, 64'd0, "unmapped read");
        read_word(64'h0000_0001_0000_1000, got);
        expect_value(got, 64'd0, "high unmapped read");
        finish_test("ram_traffic");

        // Known keys, each acknowledged
        foreach (keys[k]) begin
            send_frame(keys[k], 1'b0);
            wait_for_irq("key frame");
            read_word({32'd0, `KEY_ADDR}, got);
            expect_value(got, {56'd0, ascii_of(keys[k])}, "key value");
            expect_value({63'd0, irq}, 64'd1, "irq before ack");
            irq_ack = 1'b1;
            next_cycle();
            irq_ack = 1'b0;
            expect_value({63'd0, irq}, 64'd0, "irq after ack");
            last_key = ascii_of(keys[k]);
        end
        finish_test("key_press");

        // Bad parity, unknown code, then a release
        send_frame(8'h1C, 1'b1);
        expect_value({63'd0, irq}, 64'd0, "irq after bad parity");
        send_frame(8'h76, 1'b0);
        expect_value({63'd0, irq}, 64'd0, "irq after unknown code");
        send_frame(`PS2_BREAK, 1'b0);
        send_frame(8'h1C, 1'b0);
        expect_value({63'd0, irq}, 64'd0, "irq after release");
        read_word({32'd0, `KEY_ADDR}, got);
        expect_value(got, {56'd0, last_key}, "key value after rejects");
        finish_test("rejected_input");

        // Held write, one strobe
        start = pulse_count;
        bus_address = {32'd0, `CONSOLE_ADDR};
        bus_write_data = 64'h1234_5678_9ABC_2A41;
        bus_write_enable = 1'b1;
        repeat (3) next_cycle();
        bus_write_enable = 1'b0;
        repeat (4) next_cycle();
        expect_value(64'(pulse_count - start), 64'd1, "console pulse count");
        expect_value({56'd0, console_seen}, 64'h41, "console char");
        start = pulse_count;
        repeat (10) next_cycle();
        expect_value(64'(pulse_count - start), 64'd0, "pulses with no write");
        finish_test("console");

        $display("%0d tests run, error count %0d", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
